// File: sim.f
+incdir+src
src/lsq_pkg.sv
src/load_store_queue.sv
src/lsu_ctrl.sv
src/mem_arbiter.sv
src/data_ram.sv
src/mem_stage_top.sv
tests/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

export_include_dirs:
  - src

sources:
  - files:
      - src/lsq_pkg.sv
      - src/load_store_queue.sv
      - src/lsu_ctrl.sv
      - src/mem_arbiter.sv
      - src/data_ram.sv
      - src/mem_stage_top.sv
  - target: test
    files:
      - tests/tb_mem_stage.sv

// File: tests/tb_mem_stage.sv
`default_nettype none

`include "lsq_config.svh"

module tb_mem_stage;
    import lsq_pkg::*;

    localparam int NUM_OPS   = 226;   // Ext init writes plus every LSU operation
    localparam int LIMIT     = 10 * NUM_OPS + 200;
    localparam int EXT_BASE  = 32;    // Ext reads sweep words 32 to 41
    localparam int EXT_WORDS = 10;

    logic       clk_i = 1'b0;
    logic       rstn_i;
    lsq_instr_t instr_i;
    logic       flush_i;
    mem_req_t   ext_req_i;
    lsq_resp_t  resp_o;
    mem_rsp_t   ext_rsp_o;
    logic       ext_grant_o;
    logic       full_o;
    logic       empty_o;
    logic       pmu_load_after_store_o;

    logic [7:0] model [`RAM_WORDS * `XBYTES];   // Byte image of the RAM
    lsq_resp_t  exp_q [$];                      // Expected responses in program order
    logic [3:0] tag_cnt;
    logic       ext_rd_pending;
    mem_rsp_t   ext_exp;
    logic       ext_stop;
    logic       full_seen;
    int         errors;
    int         checks;
    int         cycle_cnt = 0;
    int         pmu_cnt;
    int         ext_cnt;
    int         replays;

    mem_stage_top uut (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic int op_bytes(input mem_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    // Little endian bytes from the model, sign extended for LB/LH/LW
    function automatic logic [`XLEN-1:0] ref_load(input mem_op_e op, input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] val;
        int               n;
        n   = op_bytes(op);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[8*i +: 8] = model[addr[`RAM_AW+2:0] + i];
        end
        if (op inside {LB, LH, LW} && val[8*n-1]) begin
            for (int i = n; i < `XBYTES; i++) begin
                val[8*i +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    function automatic logic [`XLEN-1:0] word_of(input int w);
        logic [`XLEN-1:0] val;
        for (int b = 0; b < `XBYTES; b++) begin
            val[8*b +: 8] = model[w * `XBYTES + b];
        end
        return val;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    task automatic check_resp(input lsq_resp_t got, input lsq_resp_t want);
        checks++;
        if (got.tag !== want.tag || got.data !== want.data) begin
            errors++;
            $display("[FAIL] %0t: resp tag %h data %h, expected tag %h data %h",
                     $time, got.tag, got.data, want.tag, want.data);
        end
    endtask

    task automatic check_ext(input mem_rsp_t got, input mem_rsp_t want);
        checks++;
        ext_cnt++;
        if (got.rdata !== want.rdata) begin
            errors++;
            $display("[FAIL] %0t: ext read data %h, expected %h", $time, got.rdata, want.rdata);
        end
    endtask

    // Outputs are read at the rising edge, half a cycle after the inputs moved
    always @(posedge clk_i) begin
        if (rstn_i) begin
            if (resp_o.valid) begin
                if (exp_q.size() == 0) begin
                    flag_error($sformatf("response with tag %h that nothing was waiting for",
                                         resp_o.tag));
                end else begin
                    check_resp(resp_o, exp_q.pop_front());
                end
            end
            if (ext_rsp_o.valid !== ext_rd_pending) begin
                flag_error("ext read response did not come exactly one cycle after its grant");
            end else if (ext_rsp_o.valid) begin
                check_ext(ext_rsp_o, ext_exp);
            end
            if (ext_grant_o && !ext_req_i.valid) begin
                flag_error("ext grant was raised without an ext request");
            end
            ext_rd_pending = ext_grant_o & ext_req_i.valid & ~ext_req_i.we;
            ext_exp        = '{valid: 1'b1, rdata: word_of(ext_req_i.addr)};
            if (pmu_load_after_store_o) pmu_cnt++;
            if (uut.reset_next) replays++;   // LSU lost the RAM port
        end
    end

    // Called at a falling edge, returns at a falling edge with the input cleared
    task automatic push(input lsq_instr_t ins);
        instr_i = ins;
        @(posedge clk_i);
        while (full_o) begin
            full_seen = 1'b1;
            @(posedge clk_i);
        end
        @(negedge clk_i);
        instr_i = '0;
    endtask

    task automatic issue(input mem_op_e op, input logic [`XLEN-1:0] addr,
                         input logic [`XLEN-1:0] data);
        lsq_resp_t want;
        want = '{valid: 1'b1, tag: tag_cnt, data: '0};
        if (op inside {SB, SH, SW, SD}) begin
            for (int i = 0; i < op_bytes(op); i++) begin
                model[addr[`RAM_AW+2:0] + i] = data[8*i +: 8];
            end
        end else begin
            want.data = ref_load(op, addr);
        end
        exp_q.push_back(want);
        push('{valid: 1'b1, op: op, tag: tag_cnt, addr: addr, data: data});
        tag_cnt++;
    endtask

    task automatic issue_random();
        mem_op_e op;
        int      n;
        int      off;
        op  = mem_op_e'($urandom_range(10, 0));
        n   = op_bytes(op);
        off = $urandom_range(8 / n - 1, 0) * n;   // Aligned to the access size
        issue(op, $urandom_range(15, 0) * 8 + off, {$urandom, $urandom});
    endtask

    // The ext agent holds its request until granted
    task automatic ext_access(input mem_req_t req);
        ext_req_i = req;
        @(posedge clk_i);
        while (!ext_grant_o) @(posedge clk_i);
        @(negedge clk_i);
        ext_req_i = '0;
    endtask

    task automatic ext_read_stream();
        int i;
        i = 0;
        while (!ext_stop) begin
            ext_access('{valid: 1'b1, we: 1'b0, be: '1, addr: EXT_BASE + i % EXT_WORDS,
                         wdata: '0});
            i++;
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk_i);
        repeat (2) @(negedge clk_i);
    endtask

    task automatic report_test(input string name, input int err_mark);
        if (errors == err_mark) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - err_mark);
        end
    endtask

    initial begin
        while (cycle_cnt < LIMIT) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int               err_mark;
        int               mark;
        logic [`XLEN-1:0] wdata;
        rstn_i         = 1'b0;
        instr_i        = '0;
        flush_i        = 1'b0;
        ext_req_i      = '0;
        tag_cnt        = '0;
        ext_rd_pending = 1'b0;
        ext_stop       = 1'b0;
        full_seen      = 1'b0;
        errors         = 0;
        checks         = 0;
        pmu_cnt        = 0;
        ext_cnt        = 0;
        replays        = 0;
        void'($urandom(67));
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        if (!full_o) flag_error("full_o was low while reset was asserted");
        rstn_i = 1'b1;

        // Words 0-15 serve the LSU streams, 32-39 the ext reads
        for (int w = 0; w < 40; w++) begin
            if (w < 16 || w >= EXT_BASE) begin
                wdata = {$urandom, $urandom};
                for (int b = 0; b < `XBYTES; b++) begin
                    model[w * `XBYTES + b] = wdata[8*b +: 8];
                end
                ext_access('{valid: 1'b1, we: 1'b1, be: '1, addr: w[`RAM_AW-1:0], wdata: wdata});
            end
        end

        err_mark = errors;
        issue(SD, 64'h140, 64'h8091_a2b3_c4d5_e6f7);
        issue(SW, 64'h148, 64'hffff_ffff_8765_4321);
        issue(SH, 64'h14c, 64'h0000_0000_0000_f00d);
        issue(SB, 64'h14e, 64'h0000_0000_0000_0080);
        issue(SB, 64'h14f, 64'h0000_0000_0000_007f);
        issue(LB, 64'h147, '0);
        issue(LBU, 64'h147, '0);
        issue(LH, 64'h146, '0);
        issue(LHU, 64'h146, '0);
        issue(LW, 64'h144, '0);
        issue(LWU, 64'h144, '0);
        issue(LD, 64'h140, '0);
        issue(LW, 64'h148, '0);
        issue(LWU, 64'h148, '0);
        issue(LH, 64'h14c, '0);
        issue(LB, 64'h14e, '0);
        issue(LBU, 64'h14e, '0);
        issue(LD, 64'h148, '0);
        drain();
        report_test("directed widths", err_mark);

        err_mark = errors;
        mark     = replays;
        ext_cnt  = 0;
        fork
            begin
                for (int i = 0; i < 150; i++) issue_random();
                drain();
                ext_stop = 1'b1;
            end
            ext_read_stream();
        join
        if (!full_seen) flag_error("full_o never rose during the random stream");
        if (ext_cnt == 0) flag_error("no ext read completed during the random stream");
        if (replays == mark) flag_error("the LSU never lost arbitration to the ext port");
        report_test("random stream with ext contention", err_mark);

        err_mark = errors;
        for (int i = 0; i < 6; i++) issue(LD, i * 8, '0);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        mark    = exp_q.size();   // Entries dropped by the flush
        exp_q.delete();
        if (mark == 0) flag_error("no entries were pending when flush was raised");
        if (!empty_o) flag_error("empty_o stayed low after the flush");
        repeat (4) @(negedge clk_i);
        issue(SD, 64'h20, 64'h0123_4567_89ab_cdef);
        issue(LD, 64'h20, '0);
        issue(SW, 64'h2c, 64'h0000_0000_fedc_ba98);
        issue(LWU, 64'h2c, '0);
        drain();
        report_test("flush", err_mark);

        err_mark = errors;
        mark     = pmu_cnt;
        for (int i = 0; i < 8; i++) issue(LBU, i * 8 + i, '0);
        drain();
        if (pmu_cnt != mark) flag_error("load-after-store pulse during a load-only stream");
        mark     = pmu_cnt;
        ext_stop = 1'b0;
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    issue(SW, (8 + i) * 8, {$urandom, $urandom});
                    issue(LW, (8 + i) * 8, '0);
                end
                drain();
                ext_stop = 1'b1;
            end
            ext_read_stream();
        join
        if (pmu_cnt == mark) flag_error("no load-after-store pulse for store then load");
        report_test("load-after-store pulse", err_mark);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/mem_stage_top.sv
`default_nettype none

module mem_stage_top (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  lsq_pkg::lsq_instr_t instr_i,
    input  logic                flush_i,
    input  lsq_pkg::mem_req_t   ext_req_i,
    output lsq_pkg::lsq_resp_t  resp_o,
    output lsq_pkg::mem_rsp_t   ext_rsp_o,
    output logic                ext_grant_o,
    output logic                full_o,
    output logic                empty_o,
    output logic                pmu_load_after_store_o
);
    import lsq_pkg::*;

    lsq_instr_t next_instr;
    logic       read_next;
    logic       reset_next;
    logic       advance_head;
    mem_req_t   lsu_req;
    mem_req_t   ram_req;
    mem_rsp_t   lsu_rsp;
    mem_rsp_t   ram_rsp;
    logic       lsu_grant;

    load_store_queue u_lsq (
        .clk_i                  (clk_i),
        .rstn_i                 (rstn_i),
        .instr_i                (instr_i),
        .flush_i                (flush_i),
        .read_next_i            (read_next),
        .reset_next_i           (reset_next),
        .advance_head_i         (advance_head),
        .next_instr_o           (next_instr),
        .full_o                 (full_o),
        .empty_o                (empty_o),
        .pmu_load_after_store_o (pmu_load_after_store_o)
    );

    lsu_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .empty_i        (empty_o),
        .next_instr_i   (next_instr),
        .read_next_o    (read_next),
        .reset_next_o   (reset_next),
        .advance_head_o (advance_head),
        .mem_req_o      (lsu_req),
        .grant_i        (lsu_grant),
        .mem_rsp_i      (lsu_rsp),
        .resp_o         (resp_o)
    );

    // Port 0 is the LSU, port 1 the external agent
    mem_arbiter u_arb (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .lsu_req_i   (lsu_req),
        .ext_req_i   (ext_req_i),
        .lsu_grant_o (lsu_grant),
        .ext_grant_o (ext_grant_o),
        .ram_req_o   (ram_req),
        .ram_rsp_i   (ram_rsp),
        .lsu_rsp_o   (lsu_rsp),
        .ext_rsp_o   (ext_rsp_o)
    );

    data_ram u_ram (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (ram_req),
        .rsp_o  (ram_rsp)
    );

endmodule

`default_nettype wire

// File: src/data_ram.sv
`default_nettype none

`include "lsq_config.svh"

module data_ram (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  lsq_pkg::mem_req_t req_i,
    output lsq_pkg::mem_rsp_t rsp_o
);
    logic [`XLEN-1:0] mem [`RAM_WORDS];
    logic [`XLEN-1:0] rdata_q;
    logic             rvalid_q;

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            if (req_i.we) begin
                for (int b = 0; b < `XBYTES; b++) begin
                    if (req_i.be[b]) begin
                        mem[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[req_i.addr];   // Whole word, lanes picked by the reader
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i.valid & ~req_i.we;
        end
    end

    assign rsp_o = '{valid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  lsq_pkg::mem_req_t lsu_req_i,
    input  lsq_pkg::mem_req_t ext_req_i,
    output logic              lsu_grant_o,
    output logic              ext_grant_o,
    output lsq_pkg::mem_req_t ram_req_o,
    input  lsq_pkg::mem_rsp_t ram_rsp_i,
    output lsq_pkg::mem_rsp_t lsu_rsp_o,
    output lsq_pkg::mem_rsp_t ext_rsp_o
);
    logic prio_ext_q;   // Ext port wins the next tie
    logic rsp_ext_q;    // Read granted last cycle belongs to ext

    assign lsu_grant_o = lsu_req_i.valid & (~ext_req_i.valid | ~prio_ext_q);
    assign ext_grant_o = ext_req_i.valid & (~lsu_req_i.valid | prio_ext_q);

    always_comb begin
        if (ext_grant_o) begin
            ram_req_o = ext_req_i;
        end else if (lsu_grant_o) begin
            ram_req_o = lsu_req_i;
        end else begin
            ram_req_o = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            prio_ext_q <= 1'b0;
            rsp_ext_q  <= 1'b0;
        end else begin
            if (lsu_req_i.valid && ext_req_i.valid) begin
                prio_ext_q <= lsu_grant_o;   // Loser of this tie wins the next
            end
            rsp_ext_q <= ext_grant_o & ~ext_req_i.we;
        end
    end

    // RAM only answers reads, so its valid already marks a read
    always_comb begin
        lsu_rsp_o = '{valid: ram_rsp_i.valid & ~rsp_ext_q, rdata: ram_rsp_i.rdata};
        ext_rsp_o = '{valid: ram_rsp_i.valid & rsp_ext_q, rdata: ram_rsp_i.rdata};
    end

    a_one_grant: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(lsu_grant_o && ext_grant_o));

    a_rsp_after_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ram_rsp_i.valid |-> $past((lsu_grant_o & ~lsu_req_i.we) | (ext_grant_o & ~ext_req_i.we)));

endmodule

`default_nettype wire

// File: src/lsu_ctrl.sv
`default_nettype none

`include "lsq_config.svh"

module lsu_ctrl (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                flush_i,
    input  logic                empty_i,
    input  lsq_pkg::lsq_instr_t next_instr_i,
    output logic                read_next_o,
    output logic                reset_next_o,
    output logic                advance_head_o,
    output lsq_pkg::mem_req_t   mem_req_o,
    input  logic                grant_i,
    input  lsq_pkg::mem_rsp_t   mem_rsp_i,
    output lsq_pkg::lsq_resp_t  resp_o
);
    import lsq_pkg::*;

    lsu_state_e       state_q;
    lsu_state_e       state_d;
    lsq_instr_t       instr_q;      // Entry held in flight
    logic             is_store;
    logic [2:0]       byte_off;
    logic [`XLEN-1:0] load_data;
    logic             resp_valid_q;
    logic [3:0]       resp_tag_q;
    logic [`XLEN-1:0] resp_data_q;

    function automatic logic [`XLEN-1:0] extend_load(input mem_op_e op,
                                                     input logic [`XLEN-1:0] word,
                                                     input logic [2:0] off);
        logic [`XLEN-1:0] lane;
        lane = word >> {off, 3'b000};   // Move the addressed bytes to the bottom
        case (op)
            LB:      return {{(`XLEN-8){lane[7]}}, lane[7:0]};
            LH:      return {{(`XLEN-16){lane[15]}}, lane[15:0]};
            LW:      return {{(`XLEN-32){lane[31]}}, lane[31:0]};
            LBU:     return {{(`XLEN-8){1'b0}}, lane[7:0]};
            LHU:     return {{(`XLEN-16){1'b0}}, lane[15:0]};
            LWU:     return {{(`XLEN-32){1'b0}}, lane[31:0]};
            default: return lane;       // LD
        endcase
    endfunction

    assign is_store  = instr_q.op inside {SB, SH, SW, SD};
    assign byte_off  = instr_q.addr[2:0];
    assign load_data = extend_load(instr_q.op, mem_rsp_i.rdata, byte_off);

    always_comb begin
        mem_req_o       = '0;
        mem_req_o.valid = (state_q == ISSUE) & ~flush_i;
        mem_req_o.we    = is_store;
        mem_req_o.addr  = instr_q.addr[`RAM_AW+2:3];
        case (instr_q.op)
            SB, LB, LBU: mem_req_o.be = 8'h01 << byte_off;
            SH, LH, LHU: mem_req_o.be = 8'h03 << byte_off;
            SW, LW, LWU: mem_req_o.be = 8'h0f << byte_off;
            default:     mem_req_o.be = 8'hff;
        endcase
        if (is_store) begin
            mem_req_o.wdata = instr_q.data << {byte_off, 3'b000};
        end
    end

    always_comb begin
        state_d        = state_q;
        read_next_o    = 1'b0;
        reset_next_o   = 1'b0;
        advance_head_o = 1'b0;
        if (flush_i) begin
            state_d = IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (!empty_i) begin
                        read_next_o = 1'b1;
                        state_d     = ISSUE;
                    end
                end
                ISSUE: begin
                    if (!grant_i) begin
                        reset_next_o = 1'b1;    // Lost the RAM, replay from head
                        state_d      = IDLE;
                    end else if (is_store) begin
                        advance_head_o = 1'b1;
                        state_d        = IDLE;
                    end else begin
                        state_d = WAIT;
                    end
                end
                WAIT: begin
                    if (mem_rsp_i.valid) begin
                        advance_head_o = 1'b1;
                        state_d        = IDLE;
                    end
                end
                default: state_d = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q      <= IDLE;
            resp_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            resp_valid_q <= advance_head_o;   // One response per retired entry
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_next_o) begin
            instr_q <= next_instr_i;
        end
        if (advance_head_o) begin
            resp_tag_q  <= instr_q.tag;
            resp_data_q <= is_store ? '0 : load_data;
        end
    end

    assign resp_o = '{valid: resp_valid_q, tag: resp_tag_q, data: resp_data_q};

    // Only a granted load is answered, one cycle later while still in WAIT
    a_rsp_in_wait: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_rsp_i.valid |-> (state_q == WAIT));

endmodule

`default_nettype wire

// File: src/load_store_queue.sv
`default_nettype none

`include "lsq_config.svh"

module load_store_queue (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  lsq_pkg::lsq_instr_t instr_i,
    input  logic                flush_i,
    input  logic                read_next_i,     // Take the next entry to execute
    input  logic                reset_next_i,    // Rewind next to head for replay
    input  logic                advance_head_i,  // Retire the oldest entry
    output lsq_pkg::lsq_instr_t next_instr_o,
    output logic                full_o,
    output logic                empty_o,
    output logic                pmu_load_after_store_o
);
    import lsq_pkg::*;

    logic [`LSQ_PTR_W-1:0] tail_q;   // Next free slot
    logic [`LSQ_PTR_W-1:0] next_q;   // Next entry to execute
    logic [`LSQ_PTR_W-1:0] head_q;   // Oldest entry not retired
    logic [`LSQ_PTR_W-1:0] prev_ptr;

    // One bit wider than the pointers
    logic [`LSQ_PTR_W:0] num_q;
    logic [`LSQ_PTR_W:0] num_to_exe_q;
    logic [`LSQ_PTR_W:0] num_on_fly_q;

    logic write_en;
    logic read_en;
    logic adv_en;

    lsq_instr_t entries [`LSQ_DEPTH];

    function automatic logic is_load(input mem_op_e op);
        return op inside {LB, LH, LW, LD, LBU, LHU, LWU};
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

    assign write_en = instr_i.valid & ~full_o;
    assign read_en  = read_next_i & (num_to_exe_q != 0) & ~reset_next_i;
    assign adv_en   = advance_head_i & ((num_on_fly_q != 0) | read_en);

    always_ff @(posedge clk_i) begin
        if (write_en) begin
            entries[tail_q] <= instr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            tail_q       <= '0;
            next_q       <= '0;
            head_q       <= '0;
            num_q        <= '0;
            num_to_exe_q <= '0;
            num_on_fly_q <= '0;
        end else if (flush_i) begin
            tail_q       <= '0;
            next_q       <= '0;
            head_q       <= '0;
            num_q        <= '0;
            num_to_exe_q <= '0;
            num_on_fly_q <= '0;
        end else if (reset_next_i) begin
            // Everything in flight becomes executable again
            tail_q       <= tail_q + write_en;
            next_q       <= head_q + adv_en;
            head_q       <= head_q + adv_en;
            num_q        <= num_q + write_en - adv_en;
            num_to_exe_q <= num_to_exe_q + write_en + num_on_fly_q - adv_en;
            num_on_fly_q <= '0;
        end else begin
            tail_q       <= tail_q + write_en;
            next_q       <= next_q + read_en;
            head_q       <= head_q + adv_en;
            num_q        <= num_q + write_en - adv_en;
            num_to_exe_q <= num_to_exe_q + write_en - read_en;
            num_on_fly_q <= num_on_fly_q + read_en - adv_en;
        end
    end

    assign next_instr_o = read_en ? entries[next_q] : '0;

    assign empty_o = (num_to_exe_q == 0);
    assign full_o  = (num_q == `LSQ_DEPTH) | flush_i | ~rstn_i;

    // The entry just before next is only meaningful while it is still in flight
    assign prev_ptr = next_q - 1'b1;
    assign pmu_load_after_store_o = ~read_en
                                  & (num_to_exe_q != 0)
                                  & (num_on_fly_q != 0)
                                  & is_load(entries[next_q].op)
                                  & is_store(entries[prev_ptr].op);

    // Controller retires only what it has taken from the queue
    a_adv_in_flight: assert property (@(posedge clk_i) disable iff (!rstn_i)
        advance_head_i |-> (num_on_fly_q != 0));

    a_num_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        num_q <= `LSQ_DEPTH);

endmodule

`default_nettype wire

// File: src/lsq_pkg.sv
`default_nettype none

`include "lsq_config.svh"

package lsq_pkg;

    typedef enum logic [3:0] {
        LB, LH, LW, LD, LBU, LHU, LWU,  // Loads
        SB, SH, SW, SD                  // Stores
    } mem_op_e;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT
    } lsu_state_e;

    typedef struct packed {
        logic             valid;
        mem_op_e          op;
        logic [3:0]       tag;
        logic [`XLEN-1:0] addr;   // Byte address
        logic [`XLEN-1:0] data;   // Store data, low aligned
    } lsq_instr_t;

    typedef struct packed {
        logic             valid;
        logic [3:0]       tag;
        logic [`XLEN-1:0] data;   // Zero for stores
    } lsq_resp_t;

    typedef struct packed {
        logic               valid;
        logic               we;
        logic [`XBYTES-1:0] be;
        logic [`RAM_AW-1:0] addr;   // Word index
        logic [`XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: src/lsq_config.svh
`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

// Queue geometry
`define LSQ_DEPTH 8
`define LSQ_PTR_W $clog2(`LSQ_DEPTH)

// Datapath
`define XLEN 64
`define XBYTES (`XLEN / 8)

// Data RAM, one word per XLEN bits
`define RAM_WORDS 256
`define RAM_AW $clog2(`RAM_WORDS)

`endif
